//--- Makefile
# Verilator build and run of the vector load/store unit testbench

VERILATOR ?= verilator
TOP       ?= vls_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/vls_checker.sv
// bound into vls_address_scheduler; sees only its state and request strobes, not the memory side
`default_nettype none
`timescale 1ns/10ps

module vls_checker (
  input logic               CLK,
  input logic               nRST,
  input vls_pkg::vls_state_t state,
  input logic               ren,
  input logic               wen,
  input logic               exception
);
  import vls_pkg::*;

  int fails = 0;

  // one direction at a time on the memory port
  assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
  else
  begin
    $error("read and write requested together");
    fails++;
  end

  // idle and exception states never request
  assert property (@(posedge CLK) disable iff (!nRST)
                   ((state == IDLE) || (state == EX)) |-> !(ren || wen))
  else
  begin
    $error("memory request outside an access state");
    fails++;
  end

  assert property (@(posedge CLK) disable iff (!nRST) exception |-> !(ren || wen))
  else
  begin
    $error("memory request while exception is raised");
    fails++;
  end

endmodule

bind vls_address_scheduler vls_checker u_chk (
  .CLK(CLK), .nRST(nRST), .state(state), .ren(ren), .wen(wen), .exception(exception)
);

`default_nettype wire

//--- dv/vls_monitor.sv
// expects begin_test before each instruction and end_test after it; memory is 16 words deep
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_monitor (
  input logic                 CLK,
  input logic                 nRST,
  input logic [`VLS_XLEN-1:0] mem_addr,
  input logic [`VLS_XLEN-1:0] mem_wdata,
  input logic                 mem_ren,
  input logic                 mem_wen,
  input logic [1:0]           mem_byte_ena,
  input logic                 mem_dhit,
  input logic [`VLS_XLEN-1:0] mem_rdata,
  input logic                 busy,
  input logic                 exception,
  input logic                 done,
  input logic [4:0]           vd_idx,
  input logic [`VLS_XLEN-1:0] vd_data0,
  input logic [`VLS_XLEN-1:0] vd_data1
);
  string                name;
  string                first_err;
  logic [`VLS_XLEN-1:0] e_a0;
  logic [`VLS_XLEN-1:0] e_a1;
  logic [`VLS_XLEN-1:0] e_sw0;
  logic [`VLS_XLEN-1:0] e_sw1;
  logic [`VLS_XLEN-1:0] exp_a;
  logic [`VLS_XLEN-1:0] got0;
  logic [`VLS_XLEN-1:0] got1;
  logic [1:0]           e_be;
  logic [4:0]           e_vd;
  logic                 e_ex;
  logic                 e_ld;
  int                   acc_cnt = 0;
  int                   exp_n;
  int                   pass_cnt = 0;
  int                   fail_cnt = 0;

  // zero extension of a loaded word to the element size
  function automatic logic [`VLS_XLEN-1:0] mask_to_width(input logic [`VLS_XLEN-1:0] w,
                                                         input logic [1:0] be);
    case (be)
      2'd0: mask_to_width = w;
      2'd1: mask_to_width = w & 32'h0000_ffff;
      default: mask_to_width = w & 32'h0000_00ff;
    endcase
  endfunction

  // keeps only the first problem of a test for its report line
  task automatic note(input string msg);
    if (first_err == "")
      first_err = msg;
  endtask

  task automatic begin_test(input string n, input logic [31:0] a0, input logic [31:0] a1,
                            input logic [1:0] be, input logic ex, input logic [31:0] sw0,
                            input logic [31:0] sw1, input logic [4:0] vd, input logic ld);
    name = n;
    e_a0 = a0;
    e_a1 = a1;
    e_be = be;
    e_ex = ex;
    e_sw0 = sw0;
    e_sw1 = sw1;
    e_vd = vd;
    e_ld = ld;
    acc_cnt = 0;
    first_err = "";
  endtask

  // busy spans the operation and is low again in the done or exception cycle
  task automatic check_busy();
    logic exp_busy;
    exp_busy = !(done || exception);
    if (busy !== exp_busy)
      note($sformatf("FAILED %s busy expected %0b actual %0b", name, exp_busy, busy));
  endtask

  // every completed access is checked in its dhit cycle
  always @(posedge CLK)
  begin
    if (nRST && mem_dhit && (mem_ren || mem_wen))
    begin
      exp_a = (acc_cnt == 0) ? e_a0 : e_a1;
      if (acc_cnt > 1)
        note($sformatf("%s: more than two memory accesses", name));
      else
      begin
        if (mem_addr !== exp_a)
          note($sformatf("FAILED %s addr%0d expected %h actual %h",
                         name, acc_cnt, exp_a, mem_addr));
        if (mem_byte_ena !== e_be)
          note($sformatf("FAILED %s byte_ena expected %0d actual %0d",
                         name, e_be, mem_byte_ena));
        if (mem_ren !== e_ld)
          note($sformatf("%s: access %0d went the wrong direction", name, acc_cnt));
        if (mem_wen && (mem_wdata !== ((acc_cnt == 0) ? e_sw0 : e_sw1)))
          note($sformatf("FAILED %s wdata%0d expected %h actual %h", name, acc_cnt,
                         (acc_cnt == 0) ? e_sw0 : e_sw1, mem_wdata));
        if (acc_cnt == 0)
          got0 = mem_rdata;
        else
          got1 = mem_rdata;
      end
      acc_cnt++;
    end
  end

  task automatic end_test(input logic timed_out);
    if (timed_out)
      note($sformatf("%s: timed out waiting for done or exception", name));
    else
    begin
      // misaligned base faults before any access, a bad second address after one
      exp_n = e_ex ? ((e_a0[1:0] != 2'b00) ? 0 : 1) : 2;
      if (acc_cnt != exp_n)
        note($sformatf("FAILED %s accesses expected %0d actual %0d", name, exp_n, acc_cnt));
      if (exception !== e_ex)
        note($sformatf("FAILED %s exception expected %0b actual %0b", name, e_ex, exception));
      if (!e_ex && e_ld)
      begin
        if (vd_idx !== e_vd)
          note($sformatf("FAILED %s vd_idx expected %0d actual %0d", name, e_vd, vd_idx));
        if (vd_data0 !== mask_to_width(got0, e_be))
          note($sformatf("FAILED %s vd_data0 expected %h actual %h",
                         name, mask_to_width(got0, e_be), vd_data0));
        if (vd_data1 !== mask_to_width(got1, e_be))
          note($sformatf("FAILED %s vd_data1 expected %h actual %h",
                         name, mask_to_width(got1, e_be), vd_data1));
      end
      if (!e_ex && !e_ld)
      begin
        if (vls_tb.mem[e_a0[5:2]] !== e_sw0)
          note($sformatf("FAILED %s mem0 expected %h actual %h",
                         name, e_sw0, vls_tb.mem[e_a0[5:2]]));
        if (vls_tb.mem[e_a1[5:2]] !== e_sw1)
          note($sformatf("FAILED %s mem1 expected %h actual %h",
                         name, e_sw1, vls_tb.mem[e_a1[5:2]]));
      end
    end
    if (first_err == "")
    begin
      pass_cnt++;
      $display("PASS   %s", name);
    end
    else
    begin
      fail_cnt++;
      $display("%s", first_err);
    end
  endtask

  task automatic report_counts();
    $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
  endtask

endmodule

`default_nettype wire

//--- dv/vls_tb.sv
// memory model is 16 words, byte addresses 0 to 63 only; stalls of 0 to 3 cycles from a fixed seed
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_tb;
  import vls_pkg::*;

  localparam int TIMEOUT = 200;

  logic                 CLK = 1'b0;
  logic                 nRST = 1'b0;
  logic                 instr_valid = 1'b0;
  vmem_instr_u          instr = '0;
  logic [`VLS_XLEN-1:0] base = '0;
  logic [`VLS_XLEN-1:0] stride = '0;
  logic [`VLS_XLEN-1:0] idx0 = '0;
  logic [`VLS_XLEN-1:0] idx1 = '0;
  logic [`VLS_XLEN-1:0] sdata0 = '0;
  logic [`VLS_XLEN-1:0] sdata1 = '0;
  sew_t                 sew = SEW32;
  logic                 mem_dhit = 1'b0;
  logic [`VLS_XLEN-1:0] mem_rdata = '0;
  logic                 returnex = 1'b0;
  logic [`VLS_XLEN-1:0] mem_addr;
  logic [`VLS_XLEN-1:0] mem_wdata;
  logic                 mem_ren;
  logic                 mem_wen;
  byte_ena_t            mem_byte_ena;
  logic                 busy;
  logic                 exception;
  logic                 done;
  logic [4:0]           vd_idx;
  logic [`VLS_XLEN-1:0] vd_data0;
  logic [`VLS_XLEN-1:0] vd_data1;

  logic [`VLS_XLEN-1:0] mem [0:15];
  logic [1:0]           stall = 2'd0;
  int                   seed = 41397;
  int                   rnd;

  // stimulus table, one entry per instruction
  string                t_name[$];
  logic [31:0]          t_instr[$];
  logic [31:0]          t_base[$];
  logic [31:0]          t_stride[$];
  logic [31:0]          t_idx0[$];
  logic [31:0]          t_idx1[$];
  logic [31:0]          t_sd0[$];
  logic [31:0]          t_sd1[$];
  sew_t                 t_sew[$];
  logic [31:0]          t_a0[$];
  logic [31:0]          t_a1[$];
  byte_ena_t            t_be[$];
  logic                 t_ex[$];

  always #50 CLK = ~CLK;

  vls_unit DUT (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr),
    .base(base), .stride(stride), .idx0(idx0), .idx1(idx1),
    .sdata0(sdata0), .sdata1(sdata1), .sew(sew), .mem_dhit(mem_dhit),
    .mem_rdata(mem_rdata), .returnex(returnex), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_byte_ena(mem_byte_ena), .busy(busy), .exception(exception), .done(done),
    .vd_idx(vd_idx), .vd_data0(vd_data0), .vd_data1(vd_data1)
  );

  vls_monitor mon (
    .CLK(CLK), .nRST(nRST), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_byte_ena(mem_byte_ena),
    .mem_dhit(mem_dhit), .mem_rdata(mem_rdata), .busy(busy), .exception(exception),
    .done(done), .vd_idx(vd_idx), .vd_data0(vd_data0), .vd_data1(vd_data1)
  );

  // memory answers after a random stall, one dhit cycle per request
  always @(posedge CLK)
  begin
    if (mem_dhit)
      mem_dhit <= 1'b0;
    else if (nRST && (mem_ren || mem_wen))
    begin
      if (stall == 2'd0)
      begin
        mem_dhit <= 1'b1;
        if (mem_wen)
          mem[mem_addr[5:2]] <= mem_wdata;
        else
          mem_rdata <= mem[mem_addr[5:2]];
        rnd = $random(seed);
        stall <= rnd[1:0];
      end
      else
        stall <= stall - 2'd1;
    end
  end

  // rs1 field fixed, vm set, nf and mew zero
  function automatic logic [31:0] build_instr(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [2:0] wid, input logic [1:0] mode);
    build_instr = {4'b0000, mode, 1'b1, 5'd0, 5'd10, wid, rd, opc};
  endfunction

  task automatic add_row(input string n, input logic [31:0] ins, input logic [31:0] b,
                         input logic [31:0] s, input logic [31:0] i0, input logic [31:0] i1,
                         input logic [31:0] d0, input logic [31:0] d1, input sew_t sw,
                         input logic [31:0] a0, input logic [31:0] a1, input byte_ena_t be,
                         input logic ex);
    t_name.push_back(n);
    t_instr.push_back(ins);
    t_base.push_back(b);
    t_stride.push_back(s);
    t_idx0.push_back(i0);
    t_idx1.push_back(i1);
    t_sd0.push_back(d0);
    t_sd1.push_back(d1);
    t_sew.push_back(sw);
    t_a0.push_back(a0);
    t_a1.push_back(a1);
    t_be.push_back(be);
    t_ex.push_back(ex);
  endtask

  initial
  begin
    int  row;
    int  cycles;
    logic stop;
    stop = 1'b0;
    for (int i = 0; i < 16; i++)
      mem[i] = $random(seed);
    add_row("ld_unit32", build_instr(`VLS_OP_LOAD, 5'd3, 3'b110, 2'b00), 32'h10, 0, 0, 0,
            0, 0, SEW8, 32'h10, 32'h14, BE_WORD, 1'b0);
    add_row("ld_unit16", build_instr(`VLS_OP_LOAD, 5'd5, 3'b101, 2'b00), 32'h20, 0, 0, 0,
            0, 0, SEW32, 32'h20, 32'h22, BE_HALF, 1'b1);
    add_row("ld_unit8", build_instr(`VLS_OP_LOAD, 5'd6, 3'b000, 2'b00), 32'h24, 0, 0, 0,
            0, 0, SEW32, 32'h24, 32'h25, BE_BYTE, 1'b1);
    add_row("st_stride", build_instr(`VLS_OP_STORE, 5'd7, 3'b110, 2'b10), 32'h08, 32'h0c, 0, 0,
            32'hcafe0001, 32'h1234abcd, SEW8, 32'h08, 32'h14, BE_WORD, 1'b0);
    add_row("ld_stride", build_instr(`VLS_OP_LOAD, 5'd8, 3'b110, 2'b10), 32'h08, 32'h0c, 0, 0,
            0, 0, SEW8, 32'h08, 32'h14, BE_WORD, 1'b0);
    add_row("ld_idx_sew32", build_instr(`VLS_OP_LOAD, 5'd9, 3'b000, 2'b01), 32'h04, 0, 32'h08,
            32'h1c, 0, 0, SEW32, 32'h0c, 32'h20, BE_WORD, 1'b0);
    add_row("ld_idx_sew16", build_instr(`VLS_OP_LOAD, 5'd10, 3'b110, 2'b11), 32'h30, 0, 0,
            32'h04, 0, 0, SEW16, 32'h30, 32'h34, BE_HALF, 1'b0);
    add_row("ld_idx_sew8", build_instr(`VLS_OP_LOAD, 5'd11, 3'b101, 2'b01), 32'h00, 0, 32'h28,
            32'h3c, 0, 0, SEW8, 32'h28, 32'h3c, BE_BYTE, 1'b0);
    add_row("ld_bad_base", build_instr(`VLS_OP_LOAD, 5'd12, 3'b110, 2'b00), 32'h11, 0, 0, 0,
            0, 0, SEW32, 32'h11, 32'h15, BE_WORD, 1'b1);
    add_row("st_bad_second", build_instr(`VLS_OP_STORE, 5'd13, 3'b110, 2'b10), 32'h18, 32'h06,
            0, 0, 32'h5a5a0f0f, 32'h0badf00d, SEW32, 32'h18, 32'h1e, BE_WORD, 1'b1);
    add_row("ld_after_ex", build_instr(`VLS_OP_LOAD, 5'd14, 3'b110, 2'b00), 32'h38, 0, 0, 0,
            0, 0, SEW8, 32'h38, 32'h3c, BE_WORD, 1'b0);
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    row = 0;
    while (!stop && (row < t_name.size()))
    begin
      mon.begin_test(t_name[row], t_a0[row], t_a1[row], t_be[row], t_ex[row], t_sd0[row],
                     t_sd1[row], t_instr[row][11:7], t_instr[row][6:0] == `VLS_OP_LOAD);
      @(posedge CLK);
      instr_valid <= 1'b1;
      instr <= t_instr[row];
      base <= t_base[row];
      stride <= t_stride[row];
      idx0 <= t_idx0[row];
      idx1 <= t_idx1[row];
      sdata0 <= t_sd0[row];
      sdata1 <= t_sd1[row];
      sew <= t_sew[row];
      @(posedge CLK);
      instr_valid <= 1'b0;
      cycles = 0;
      // every cycle from the one after acceptance is checked for busy
      while (!done && !exception && (cycles < TIMEOUT))
      begin
        @(posedge CLK);
        cycles++;
        mon.check_busy();
      end
      mon.end_test(cycles >= TIMEOUT);
      if (cycles >= TIMEOUT)
        stop = 1'b1;
      else if (exception)
      begin
        // leave the exception state before the next row
        returnex <= 1'b1;
        @(posedge CLK);
        returnex <= 1'b0;
        cycles = 0;
        while (exception && (cycles < TIMEOUT))
        begin
          @(posedge CLK);
          cycles++;
        end
        if (cycles >= TIMEOUT)
        begin
          $display("exception did not clear after returnex");
          stop = 1'b1;
        end
      end
      row++;
    end
    mon.report_counts();
    if (!stop && (mon.fail_cnt == 0) && (DUT.u_sched.u_chk.fails == 0))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/vls_config.svh
// widths and opcodes shared by RTL and testbench; the instruction union assumes a 32-bit word
`ifndef VLS_CONFIG_SVH
`define VLS_CONFIG_SVH

// address and data path width
`define VLS_XLEN 32

// elements moved per vector instruction, fixed at two
`define VLS_NUM_ELEM 2

// major opcodes of the RVV memory instructions
`define VLS_OP_LOAD  7'b0000111
`define VLS_OP_STORE 7'b0100111

// low address bits that must be zero for a word access
`define VLS_ALIGN_BITS 2

`endif

//--- src.f
+incdir+include
src/vls_pkg.sv
src/vls_decode.sv
src/vls_addr_gen.sv
src/vls_address_scheduler.sv
src/vls_result.sv
src/vls_unit.sv
dv/vls_checker.sv
dv/vls_monitor.sv
dv/vls_tb.sv

//--- src/vls_addr_gen.sv
// two element addresses only; unit stride steps by the element size, no vl or masking
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_addr_gen (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 capture,
  input  logic [`VLS_XLEN-1:0] base,
  input  logic [`VLS_XLEN-1:0] stride,
  input  logic [`VLS_XLEN-1:0] idx0,
  input  logic [`VLS_XLEN-1:0] idx1,
  input  logic [`VLS_XLEN-1:0] sdata0,
  input  logic [`VLS_XLEN-1:0] sdata1,
  input  vls_pkg::sew_t        sew,
  input  vls_pkg::mop_t        mop,
  input  vls_pkg::width_t      width,
  output logic [`VLS_XLEN-1:0] addr0,
  output logic [`VLS_XLEN-1:0] addr1,
  output logic [`VLS_XLEN-1:0] data0,
  output logic [`VLS_XLEN-1:0] data1,
  output vls_pkg::byte_ena_t   byte_ena
);
  import vls_pkg::*;

  logic [`VLS_XLEN-1:0] base_q;
  logic [`VLS_XLEN-1:0] stride_q;
  logic [`VLS_XLEN-1:0] idx0_q;
  logic [`VLS_XLEN-1:0] idx1_q;
  logic [`VLS_XLEN-1:0] elem_bytes;
  sew_t                 sew_q;
  logic                 indexed;

  // address operands held for the whole operation
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      base_q   <= '0;
      stride_q <= '0;
      idx0_q   <= '0;
      idx1_q   <= '0;
      sew_q    <= SEW32;
    end
    else if (capture)
    begin
      base_q   <= base;
      stride_q <= stride;
      idx0_q   <= idx0;
      idx1_q   <= idx1;
      sew_q    <= sew;
    end
  end

  // store words go straight to the scheduler
  always_ff @(posedge CLK)
  begin
    if (capture)
    begin
      data0 <= sdata0;
      data1 <= sdata1;
    end
  end

  assign indexed = (mop == MOP_INDEXED_UNORD) | (mop == MOP_INDEXED_ORD);

  // indexed ops size elements by the CSR sew, the rest by the instruction width
  always_comb
  begin
    if (indexed)
      byte_ena = (sew_q == SEW32) ? BE_WORD : (sew_q == SEW16) ? BE_HALF : BE_BYTE;
    else
      byte_ena = (width == WIDTH32) ? BE_WORD : (width == WIDTH16) ? BE_HALF : BE_BYTE;
  end

  always_comb
  begin
    case (byte_ena)
      BE_WORD: elem_bytes = `VLS_XLEN'd4;
      BE_HALF: elem_bytes = `VLS_XLEN'd2;
      default: elem_bytes = `VLS_XLEN'd1;
    endcase
  end

  always_comb
  begin
    case (mop)
      MOP_UNIT:
      begin
        addr0 = base_q;
        addr1 = base_q + elem_bytes;
      end
      MOP_STRIDED:
      begin
        addr0 = base_q;
        addr1 = base_q + stride_q;
      end
      // both indexed orderings behave alike with two elements
      default:
      begin
        addr0 = base_q + idx0_q;
        addr1 = base_q + idx1_q;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/vls_address_scheduler.sv
// both element addresses must be word aligned; a second-address fault leaves element 0 done
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_address_scheduler (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 load,
  input  logic                 store,
  input  logic                 returnex,
  input  logic                 dhit,
  input  logic [`VLS_XLEN-1:0] addr0,
  input  logic [`VLS_XLEN-1:0] addr1,
  input  logic [`VLS_XLEN-1:0] storedata0,
  input  logic [`VLS_XLEN-1:0] storedata1,
  output logic [`VLS_XLEN-1:0] final_addr,
  output logic [`VLS_XLEN-1:0] final_storedata,
  output logic                 ren,
  output logic                 wen,
  output logic                 arrived0,
  output logic                 arrived1,
  output logic                 finish,
  output logic                 exception,
  output logic                 busy
);
  import vls_pkg::*;

  vls_state_t state;
  vls_state_t next_state;
  logic       daccess;
  logic       misalign0;
  logic       misalign1;

  assign daccess   = load | store;
  // any nonzero low bits fault, whatever the element size
  assign misalign0 = daccess & (addr0[`VLS_ALIGN_BITS-1:0] != '0);
  assign misalign1 = daccess & (addr1[`VLS_ALIGN_BITS-1:0] != '0);

  // read data is valid in the dhit cycle of each load access
  assign arrived0  = (state == LOAD0) & dhit;
  assign arrived1  = (state == LOAD1) & dhit;
  assign finish    = dhit & ((state == LOAD1) | (state == STORE1));

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // a bad first address faults before any request
        if (misalign0)
          next_state = EX;
        else if (load)
          next_state = LOAD0;
        else if (store)
          next_state = STORE0;
      end
      LOAD0:
        if (dhit)
          next_state = misalign1 ? EX : LOAD1;
      STORE0:
        if (dhit)
          next_state = misalign1 ? EX : STORE1;
      LOAD1, STORE1:
        if (dhit)
          next_state = IDLE;
      EX:
        if (returnex)
          next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  // request held until dhit, memory stalls just stretch a state
  always_comb
  begin
    final_addr      = '0;
    final_storedata = '0;
    ren             = 1'b0;
    wen             = 1'b0;
    exception       = 1'b0;
    busy            = 1'b1;
    case (state)
      // busy already in the cycle after acceptance
      IDLE:   busy = daccess;
      LOAD0:
      begin
        final_addr = addr0;
        ren        = 1'b1;
      end
      LOAD1:
      begin
        final_addr = addr1;
        ren        = 1'b1;
      end
      STORE0:
      begin
        final_addr      = addr0;
        final_storedata = storedata0;
        wen             = 1'b1;
      end
      STORE1:
      begin
        final_addr      = addr1;
        final_storedata = storedata1;
        wen             = 1'b1;
      end
      // not busy here, but decode refuses new ops until returnex
      EX:
      begin
        busy      = 1'b0;
        exception = 1'b1;
      end
      default: busy = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/vls_decode.sv
// holds one memory instruction at a time; opcodes other than vector load or store are dropped
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_decode (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 instr_valid,
  input  vls_pkg::vmem_instr_u instr,
  input  logic                 busy,
  input  logic                 finish,
  input  logic                 exception,
  output logic                 is_load,
  output logic                 is_store,
  output vls_pkg::mop_t        mop,
  output vls_pkg::width_t      width,
  output logic [4:0]           vd_idx,
  output logic                 op_active
);
  import vls_pkg::*;

  logic accept;
  logic ld_op;
  logic st_op;

  // no new op while one is pending or an exception waits for returnex
  assign accept    = instr_valid & ~busy & ~exception & ~op_active;
  assign ld_op     = instr.ld.opcode == `VLS_OP_LOAD;
  assign st_op     = instr.st.opcode == `VLS_OP_STORE;
  assign op_active = is_load | is_store;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      is_load  <= 1'b0;
      is_store <= 1'b0;
      mop      <= MOP_UNIT;
      width    <= WIDTH32;
      vd_idx   <= '0;
    end
    else if (accept & (ld_op | st_op))
    begin
      is_load  <= ld_op;
      is_store <= st_op;
      // mode and width sit at the same bits in both views
      mop      <= instr.ld.mop;
      width    <= instr.ld.width;
      // bits 11:7 read as vd for a load, vs3 for a store
      vd_idx   <= ld_op ? instr.ld.vd : instr.st.vs3;
    end
    else if (finish | exception)
    begin
      is_load  <= 1'b0;
      is_store <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/vls_pkg.sv
// vector load/store types; the union covers only the RVV memory formats, nf and mew are ignored
`default_nettype none

package vls_pkg;

  // instruction width field, the codes of the vector memory ops
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  // element width from the vtype CSR
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // addressing mode, bit 0 set means indexed
  typedef enum logic [1:0] {
    MOP_UNIT          = 2'b00,
    MOP_INDEXED_UNORD = 2'b01,
    MOP_STRIDED       = 2'b10,
    MOP_INDEXED_ORD   = 2'b11
  } mop_t;

  // access size on the memory port
  typedef enum logic [1:0] {
    BE_WORD = 2'd0,
    BE_HALF = 2'd1,
    BE_BYTE = 2'd2
  } byte_ena_t;

  typedef enum logic [2:0] {IDLE, LOAD0, LOAD1, STORE0, STORE1, EX} vls_state_t;

  // load view, bits 11:7 name the destination
  typedef struct packed {
    logic [3:0] upper;
    mop_t       mop;
    logic       vm;
    logic [4:0] lumop_rs2;
    logic [4:0] rs1;
    width_t     width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vls_load_t;

  // store view, bits 11:7 name the data source
  typedef struct packed {
    logic [3:0] upper;
    mop_t       mop;
    logic       vm;
    logic [4:0] sumop_rs2;
    logic [4:0] rs1;
    width_t     width;
    logic [4:0] vs3;
    logic [6:0] opcode;
  } vls_store_t;

  typedef union packed {
    vls_load_t  ld;
    vls_store_t st;
  } vmem_instr_u;

endpackage

`default_nettype wire

//--- src/vls_result.sv
// load data is zero extended only; vd_data holds its value until the next load overwrites it
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_result (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 arrived0,
  input  logic                 arrived1,
  input  vls_pkg::byte_ena_t   byte_ena,
  input  logic [`VLS_XLEN-1:0] rdata,
  input  logic                 finish,
  output logic [`VLS_XLEN-1:0] vd_data0,
  output logic [`VLS_XLEN-1:0] vd_data1,
  output logic                 done
);
  import vls_pkg::*;

  // keep the low element bits, clear the rest
  function automatic logic [`VLS_XLEN-1:0] trim(input logic [`VLS_XLEN-1:0] word,
                                                input byte_ena_t           be);
    case (be)
      BE_WORD: trim = word;
      BE_HALF: trim = {{(`VLS_XLEN-16){1'b0}}, word[15:0]};
      default: trim = {{(`VLS_XLEN-8){1'b0}}, word[7:0]};
    endcase
  endfunction

  always_ff @(posedge CLK)
  begin
    if (arrived0)
      vd_data0 <= trim(rdata, byte_ena);
    if (arrived1)
      vd_data1 <= trim(rdata, byte_ena);
  end

  // done follows the last dhit by one cycle, so both elements are in place
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      done <= 1'b0;
    else
      done <= finish;
  end

endmodule

`default_nettype wire

//--- src/vls_unit.sv
// one instruction in flight; instr_valid is ignored while busy or while exception is high
`default_nettype none
`timescale 1ns/10ps
`include "vls_config.svh"

module vls_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 instr_valid,
  input  vls_pkg::vmem_instr_u instr,
  input  logic [`VLS_XLEN-1:0] base,
  input  logic [`VLS_XLEN-1:0] stride,
  input  logic [`VLS_XLEN-1:0] idx0,
  input  logic [`VLS_XLEN-1:0] idx1,
  input  logic [`VLS_XLEN-1:0] sdata0,
  input  logic [`VLS_XLEN-1:0] sdata1,
  input  vls_pkg::sew_t        sew,
  input  logic                 mem_dhit,
  input  logic [`VLS_XLEN-1:0] mem_rdata,
  input  logic                 returnex,
  output logic [`VLS_XLEN-1:0] mem_addr,
  output logic [`VLS_XLEN-1:0] mem_wdata,
  output logic                 mem_ren,
  output logic                 mem_wen,
  output vls_pkg::byte_ena_t   mem_byte_ena,
  output logic                 busy,
  output logic                 exception,
  output logic                 done,
  output logic [4:0]           vd_idx,
  output logic [`VLS_XLEN-1:0] vd_data0,
  output logic [`VLS_XLEN-1:0] vd_data1
);
  import vls_pkg::*;

  logic                 capture;
  logic                 is_load;
  logic                 is_store;
  logic                 op_active;
  mop_t                 mop;
  width_t               width;
  logic [`VLS_XLEN-1:0] addr0;
  logic [`VLS_XLEN-1:0] addr1;
  logic [`VLS_XLEN-1:0] data0;
  logic [`VLS_XLEN-1:0] data1;
  logic                 arrived0;
  logic                 arrived1;
  logic                 finish;

  // operands sampled under the same condition decode accepts on
  assign capture = instr_valid & ~busy & ~exception & ~op_active;

  vls_decode u_decode (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr),
    .busy(busy), .finish(finish), .exception(exception),
    .is_load(is_load), .is_store(is_store), .mop(mop), .width(width),
    .vd_idx(vd_idx), .op_active(op_active)
  );

  vls_addr_gen u_addr_gen (
    .CLK(CLK), .nRST(nRST), .capture(capture),
    .base(base), .stride(stride), .idx0(idx0), .idx1(idx1),
    .sdata0(sdata0), .sdata1(sdata1), .sew(sew), .mop(mop), .width(width),
    .addr0(addr0), .addr1(addr1), .data0(data0), .data1(data1),
    .byte_ena(mem_byte_ena)
  );

  vls_address_scheduler u_sched (
    .CLK(CLK), .nRST(nRST), .load(is_load), .store(is_store),
    .returnex(returnex), .dhit(mem_dhit),
    .addr0(addr0), .addr1(addr1), .storedata0(data0), .storedata1(data1),
    .final_addr(mem_addr), .final_storedata(mem_wdata),
    .ren(mem_ren), .wen(mem_wen), .arrived0(arrived0), .arrived1(arrived1),
    .finish(finish), .exception(exception), .busy(busy)
  );

  vls_result u_result (
    .CLK(CLK), .nRST(nRST), .arrived0(arrived0), .arrived1(arrived1),
    .byte_ena(mem_byte_ena), .rdata(mem_rdata), .finish(finish),
    .vd_data0(vd_data0), .vd_data1(vd_data1), .done(done)
  );

endmodule

`default_nettype wire
